//--- design/riscv_isa_pkg.sv
package riscv_isa_pkg;

  // one fetched RV32I instruction word
  typedef logic [31:0] instr_t;

  // major opcode taken from bits 6 to 2
  // the two low bits only mark the 32-bit quadrant and are checked on their own
  typedef logic [4:0]  opcode_t;

  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // major opcodes of the base integer set that this decoder accepts
  localparam opcode_t LOAD_OPCODE     = 5'b00000;
  localparam opcode_t MISC_MEM_OPCODE = 5'b00011;
  localparam opcode_t OP_IMM_OPCODE   = 5'b00100;
  localparam opcode_t AUIPC_OPCODE    = 5'b00101;
  localparam opcode_t STORE_OPCODE    = 5'b01000;
  localparam opcode_t OP_OPCODE       = 5'b01100;
  localparam opcode_t LUI_OPCODE      = 5'b01101;
  localparam opcode_t BRANCH_OPCODE   = 5'b11000;
  localparam opcode_t JALR_OPCODE     = 5'b11001;
  localparam opcode_t JAL_OPCODE      = 5'b11011;

  // funct3 of loads and stores gives the access size
  // the unsigned forms only exist for loads
  localparam funct3_t LDST_B  = 3'd0;
  localparam funct3_t LDST_H  = 3'd1;
  localparam funct3_t LDST_W  = 3'd2;
  localparam funct3_t LDST_BU = 3'd4;
  localparam funct3_t LDST_HU = 3'd5;

  // funct7 of register ops and immediate shifts
  // the alternate value selects SUB and the arithmetic right shift
  localparam funct7_t FUNCT7_BASE = 7'b0000000;
  localparam funct7_t FUNCT7_ALT  = 7'b0100000;

endpackage

//--- design/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

  // ALU operation code
  typedef logic [4:0] alu_op_t;

  // operand and write-back mux selects
  typedef logic [1:0] a_sel_t;
  typedef logic [2:0] b_sel_t;
  typedef logic [1:0] wb_sel_t;

  // memory access size, carries the LDST funct3 codes unchanged
  typedef logic [2:0] mem_size_t;

  localparam alu_op_t ALU_ADD  = 5'b00000;
  localparam alu_op_t ALU_SUB  = 5'b01000;
  localparam alu_op_t ALU_XOR  = 5'b00100;
  localparam alu_op_t ALU_OR   = 5'b00110;
  localparam alu_op_t ALU_AND  = 5'b00111;
  localparam alu_op_t ALU_SRA  = 5'b01101;
  localparam alu_op_t ALU_SRL  = 5'b00101;
  localparam alu_op_t ALU_SLL  = 5'b00001;
  localparam alu_op_t ALU_SLTS = 5'b00010;
  localparam alu_op_t ALU_SLTU = 5'b00011;

  // comparisons are 2'b11 followed by the branch funct3
  localparam alu_op_t ALU_EQ   = 5'b11000;
  localparam alu_op_t ALU_NE   = 5'b11001;
  localparam alu_op_t ALU_LTS  = 5'b11100;
  localparam alu_op_t ALU_GES  = 5'b11101;
  localparam alu_op_t ALU_LTU  = 5'b11110;
  localparam alu_op_t ALU_GEU  = 5'b11111;

  localparam a_sel_t OP_A_RS1     = 2'd0;
  localparam a_sel_t OP_A_CURR_PC = 2'd1;
  localparam a_sel_t OP_A_ZERO    = 2'd2;

  localparam b_sel_t OP_B_RS2   = 3'd0;
  localparam b_sel_t OP_B_IMM_I = 3'd1;
  localparam b_sel_t OP_B_IMM_U = 3'd2;
  localparam b_sel_t OP_B_IMM_S = 3'd3;
  // constant 4 for the link address of jumps
  localparam b_sel_t OP_B_INCR  = 3'd4;

  localparam wb_sel_t WB_ALU = 2'd0;
  localparam wb_sel_t WB_LSU = 2'd1;

endpackage

//--- design/decode_fields_if.sv
// link between the field split stage and the control decode stage
// an item moves on a clock edge where fields_valid and fields_ready are both high
interface decode_fields_if;
  import riscv_isa_pkg::*;

  logic    fields_valid;
  logic    fields_ready;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  // high when instruction bits 1 to 0 were 2'b11
  logic    quadrant_ok;

  // the split stage owns the payload and valid
  modport split_src (
    output fields_valid,
    output opcode,
    output funct3,
    output funct7,
    output quadrant_ok,
    input  fields_ready
  );

  // the decode stage only answers with ready
  modport decode_dst (
    input  fields_valid,
    input  opcode,
    input  funct3,
    input  funct7,
    input  quadrant_ok,
    output fields_ready
  );

endinterface

//--- design/field_split_stage.sv
module field_split_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  input  riscv_isa_pkg::instr_t  instr_i,
  output logic                   instr_ready_o,
  decode_fields_if.split_src     fields
);

  logic take;

  // the stage holds one item and can refill in the cycle that the decode stage drains it
  assign instr_ready_o = !fields.fields_valid || fields.fields_ready;

  // an instruction moves in on this edge
  assign take = instr_valid_i && instr_ready_o;

  // occupancy flag of the single slot
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fields.fields_valid <= 1'b0;
    end else if (take) begin
      fields.fields_valid <= 1'b1;
    end else if (fields.fields_ready) begin
      // the item left and nothing new came in
      fields.fields_valid <= 1'b0;
    end
  end

  // payload only loads on a take so it holds while the decode stage stalls
  always_ff @(posedge clk_i) begin
    if (take) begin
      fields.opcode      <= instr_i[6:2];
      fields.funct3      <= instr_i[14:12];
      fields.funct7      <= instr_i[31:25];
      // compressed and reserved quadrants are flagged here and rejected later
      fields.quadrant_ok <= (instr_i[1:0] == 2'b11);
    end
  end

  // the decode stage may not see the fields change under it while it stalls
  // and the stall itself comes back from the output side of the pipeline
  fields_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fields.fields_valid && !fields.fields_ready |=>
      fields.fields_valid &&
      $stable({fields.opcode, fields.funct3, fields.funct7, fields.quadrant_ok})
  ) else $error("field split stage changed its fields while stalled");

endmodule

//--- design/ctrl_decode_stage.sv
module ctrl_decode_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  decode_fields_if.decode_dst         fields,
  output logic                        ctrl_valid_o,
  input  logic                        ctrl_ready_i,
  output decode_ctrl_pkg::a_sel_t     a_sel_o,
  output decode_ctrl_pkg::b_sel_t     b_sel_o,
  output decode_ctrl_pkg::alu_op_t    alu_op_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output decode_ctrl_pkg::mem_size_t  mem_size_o,
  output logic                        gpr_we_o,
  output decode_ctrl_pkg::wb_sel_t    wb_sel_o,
  output logic                        illegal_instr_o,
  output logic                        branch_o,
  output logic                        jal_o,
  output logic                        jalr_o
);
  import riscv_isa_pkg::*;
  import decode_ctrl_pkg::*;

  logic      accept;
  logic      funct_ok;
  logic      is_alt;
  a_sel_t    dec_a_sel;
  b_sel_t    dec_b_sel;
  alu_op_t   dec_alu_op;
  logic      dec_mem_req;
  logic      dec_mem_we;
  mem_size_t dec_mem_size;
  logic      dec_gpr_we;
  wb_sel_t   dec_wb_sel;
  logic      dec_illegal;
  logic      dec_branch;
  logic      dec_jal;
  logic      dec_jalr;

  // integer op from funct3, alt picks SUB for 0 and SRA for 5
  function automatic alu_op_t arith_op(input funct3_t f3, input logic alt);
    case (f3)
      3'd0:    arith_op = alt ? ALU_SUB : ALU_ADD;
      3'd1:    arith_op = ALU_SLL;
      3'd2:    arith_op = ALU_SLTS;
      3'd3:    arith_op = ALU_SLTU;
      3'd4:    arith_op = ALU_XOR;
      3'd5:    arith_op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  assign is_alt = (fields.funct7 == FUNCT7_ALT);

  always_comb begin
    // default word, each opcode changes only what it needs
    dec_a_sel    = OP_A_RS1;
    dec_b_sel    = OP_B_RS2;
    dec_alu_op   = ALU_ADD;
    dec_mem_req  = 1'b0;
    dec_mem_we   = 1'b0;
    dec_mem_size = '0;
    dec_gpr_we   = 1'b0;
    dec_wb_sel   = WB_ALU;
    dec_branch   = 1'b0;
    dec_jal      = 1'b0;
    dec_jalr     = 1'b0;
    funct_ok     = 1'b1;
    case (fields.opcode)
      LOAD_OPCODE: begin
        dec_mem_req  = 1'b1;
        dec_gpr_we   = 1'b1;
        dec_wb_sel   = WB_LSU;
        dec_b_sel    = OP_B_IMM_I;
        dec_mem_size = fields.funct3;
        funct_ok     = fields.funct3 inside {LDST_B, LDST_H, LDST_W, LDST_BU, LDST_HU};
      end
      STORE_OPCODE: begin
        dec_mem_req  = 1'b1;
        dec_mem_we   = 1'b1;
        dec_b_sel    = OP_B_IMM_S;
        dec_mem_size = fields.funct3;
        // there are no unsigned stores
        funct_ok     = fields.funct3 inside {LDST_B, LDST_H, LDST_W};
      end
      BRANCH_OPCODE: begin
        dec_branch = 1'b1;
        dec_alu_op = {2'b11, fields.funct3};
        // funct3 2 and 3 have no comparison
        funct_ok   = !(fields.funct3 inside {3'd2, 3'd3});
      end
      JALR_OPCODE: begin
        dec_jalr   = 1'b1;
        dec_gpr_we = 1'b1;
        dec_a_sel  = OP_A_CURR_PC;
        dec_b_sel  = OP_B_INCR;
        funct_ok   = (fields.funct3 == 3'd0);
      end
      JAL_OPCODE: begin
        // the ALU forms pc + 4 for the link register
        dec_jal    = 1'b1;
        dec_gpr_we = 1'b1;
        dec_a_sel  = OP_A_CURR_PC;
        dec_b_sel  = OP_B_INCR;
      end
      AUIPC_OPCODE: begin
        dec_gpr_we = 1'b1;
        dec_a_sel  = OP_A_CURR_PC;
        dec_b_sel  = OP_B_IMM_U;
      end
      LUI_OPCODE: begin
        // zero plus the upper immediate
        dec_gpr_we = 1'b1;
        dec_a_sel  = OP_A_ZERO;
        dec_b_sel  = OP_B_IMM_U;
      end
      MISC_MEM_OPCODE: begin
        // fence runs as a no-op on this in-order core
        funct_ok = (fields.funct3 == 3'd0);
      end
      OP_OPCODE: begin
        dec_gpr_we = 1'b1;
        dec_alu_op = arith_op(fields.funct3, is_alt);
        funct_ok   = (fields.funct7 == FUNCT7_BASE) ||
                     (is_alt && fields.funct3 inside {3'd0, 3'd5});
      end
      OP_IMM_OPCODE: begin
        dec_gpr_we = 1'b1;
        dec_b_sel  = OP_B_IMM_I;
        // only SRAI reads funct7, elsewhere those bits belong to the immediate
        dec_alu_op = arith_op(fields.funct3, is_alt && fields.funct3 == 3'd5);
        if (fields.funct3 == 3'd1) begin
          funct_ok = (fields.funct7 == FUNCT7_BASE);
        end else if (fields.funct3 == 3'd5) begin
          funct_ok = (fields.funct7 == FUNCT7_BASE) || is_alt;
        end
      end
      default: funct_ok = 1'b0;
    endcase
    dec_illegal = !fields.quadrant_ok || !funct_ok;
    // an illegal instruction falls back to the default word with only the flag set
    if (dec_illegal) begin
      dec_a_sel    = OP_A_RS1;
      dec_b_sel    = OP_B_RS2;
      dec_alu_op   = ALU_ADD;
      dec_mem_req  = 1'b0;
      dec_mem_we   = 1'b0;
      dec_mem_size = '0;
      dec_gpr_we   = 1'b0;
      dec_wb_sel   = WB_ALU;
      dec_branch   = 1'b0;
      dec_jal      = 1'b0;
      dec_jalr     = 1'b0;
    end
  end

  // same one-slot rule as the split stage
  assign fields.fields_ready = !ctrl_valid_o || ctrl_ready_i;
  assign accept = fields.fields_valid && fields.fields_ready;

  // the word only loads on accept so every output holds during a stall
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_valid_o    <= 1'b0;
      a_sel_o         <= '0;
      b_sel_o         <= '0;
      alu_op_o        <= '0;
      mem_req_o       <= 1'b0;
      mem_we_o        <= 1'b0;
      mem_size_o      <= '0;
      gpr_we_o        <= 1'b0;
      wb_sel_o        <= '0;
      illegal_instr_o <= 1'b0;
      branch_o        <= 1'b0;
      jal_o           <= 1'b0;
      jalr_o          <= 1'b0;
    end else if (accept) begin
      ctrl_valid_o    <= 1'b1;
      a_sel_o         <= dec_a_sel;
      b_sel_o         <= dec_b_sel;
      alu_op_o        <= dec_alu_op;
      mem_req_o       <= dec_mem_req;
      mem_we_o        <= dec_mem_we;
      mem_size_o      <= dec_mem_size;
      gpr_we_o        <= dec_gpr_we;
      wb_sel_o        <= dec_wb_sel;
      illegal_instr_o <= dec_illegal;
      branch_o        <= dec_branch;
      jal_o           <= dec_jal;
      jalr_o          <= dec_jalr;
    end else if (ctrl_ready_i) begin
      ctrl_valid_o    <= 1'b0;
    end
  end

  // an illegal word must never start a side effect downstream
  illegal_quiet_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ctrl_valid_o && illegal_instr_o |->
      !(mem_req_o || mem_we_o || gpr_we_o || branch_o || jal_o || jalr_o)
  ) else $error("illegal control word carries an enable");

  // a stalled word stays valid and unchanged until the consumer takes it
  ctrl_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ctrl_valid_o && !ctrl_ready_i |=>
      ctrl_valid_o &&
      $stable({a_sel_o, b_sel_o, alu_op_o, mem_req_o, mem_we_o, mem_size_o, gpr_we_o,
               wb_sel_o, illegal_instr_o, branch_o, jal_o, jalr_o})
  ) else $error("control word changed while stalled");

endmodule

//--- design/instr_decoder_top.sv
// two-stage pipelined decoder
// stage one splits the instruction fields and stage two registers the control word
module instr_decoder_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        instr_valid_i,
  input  riscv_isa_pkg::instr_t       instr_i,
  output logic                        instr_ready_o,
  output logic                        ctrl_valid_o,
  input  logic                        ctrl_ready_i,
  output decode_ctrl_pkg::a_sel_t     a_sel_o,
  output decode_ctrl_pkg::b_sel_t     b_sel_o,
  output decode_ctrl_pkg::alu_op_t    alu_op_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output decode_ctrl_pkg::mem_size_t  mem_size_o,
  output logic                        gpr_we_o,
  output decode_ctrl_pkg::wb_sel_t    wb_sel_o,
  output logic                        illegal_instr_o,
  output logic                        branch_o,
  output logic                        jal_o,
  output logic                        jalr_o
);

  // stream between the stages
  decode_fields_if fields_if ();

  field_split_stage field_split_stage_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .fields        (fields_if.split_src)
  );

  // ready of this stage ripples back through the split stage to instr_ready_o
  ctrl_decode_stage ctrl_decode_stage_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fields          (fields_if.decode_dst),
    .ctrl_valid_o    (ctrl_valid_o),
    .ctrl_ready_i    (ctrl_ready_i),
    .a_sel_o         (a_sel_o),
    .b_sel_o         (b_sel_o),
    .alu_op_o        (alu_op_o),
    .mem_req_o       (mem_req_o),
    .mem_we_o        (mem_we_o),
    .mem_size_o      (mem_size_o),
    .gpr_we_o        (gpr_we_o),
    .wb_sel_o        (wb_sel_o),
    .illegal_instr_o (illegal_instr_o),
    .branch_o        (branch_o),
    .jal_o           (jal_o),
    .jalr_o          (jalr_o)
  );

endmodule

//--- include/decoder_ref_model.svh
`ifndef DECODER_REF_MODEL_SVH
`define DECODER_REF_MODEL_SVH

// expected ALU code of a register or immediate integer op
function automatic decode_ctrl_pkg::alu_op_t alu_code_for(input logic [2:0] f3,
                                                          input logic alt);
  case (f3)
    3'd0:    alu_code_for = alt ? decode_ctrl_pkg::ALU_SUB : decode_ctrl_pkg::ALU_ADD;
    3'd1:    alu_code_for = decode_ctrl_pkg::ALU_SLL;
    3'd2:    alu_code_for = decode_ctrl_pkg::ALU_SLTS;
    3'd3:    alu_code_for = decode_ctrl_pkg::ALU_SLTU;
    3'd4:    alu_code_for = decode_ctrl_pkg::ALU_XOR;
    3'd5:    alu_code_for = alt ? decode_ctrl_pkg::ALU_SRA : decode_ctrl_pkg::ALU_SRL;
    3'd6:    alu_code_for = decode_ctrl_pkg::ALU_OR;
    default: alu_code_for = decode_ctrl_pkg::ALU_AND;
  endcase
endfunction

// expected control word packed in this order
// a_sel, b_sel, alu_op, mem_req, mem_we, mem_size, gpr_we, wb_sel, illegal, branch, jal, jalr
function automatic logic [23:0] expected_ctrl_word(input riscv_isa_pkg::instr_t instr);
  logic [4:0] op;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       alt;
  logic       ok;
  logic [23:0] word;
  op   = instr[6:2];
  f3   = instr[14:12];
  f7   = instr[31:25];
  alt  = (f7 == riscv_isa_pkg::FUNCT7_ALT);
  ok   = 1'b1;
  // default word is all zero in this packing
  word = '0;
  case (op)
    riscv_isa_pkg::LOAD_OPCODE: begin
      word = {2'd0, 3'd1, 5'd0, 1'b1, 1'b0, f3, 1'b1, 2'd1, 4'b0};
      ok   = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    end
    riscv_isa_pkg::STORE_OPCODE: begin
      word = {2'd0, 3'd3, 5'd0, 1'b1, 1'b1, f3, 1'b0, 2'd0, 4'b0};
      ok   = f3 inside {3'd0, 3'd1, 3'd2};
    end
    riscv_isa_pkg::BRANCH_OPCODE: begin
      word = {2'd0, 3'd0, 2'b11, f3, 1'b0, 1'b0, 3'd0, 1'b0, 2'd0, 4'b0100};
      ok   = !(f3 inside {3'd2, 3'd3});
    end
    riscv_isa_pkg::JALR_OPCODE: begin
      word = {2'd1, 3'd4, 5'd0, 1'b0, 1'b0, 3'd0, 1'b1, 2'd0, 4'b0001};
      ok   = (f3 == 3'd0);
    end
    riscv_isa_pkg::JAL_OPCODE:   word = {2'd1, 3'd4, 5'd0, 5'd0, 1'b1, 2'd0, 4'b0010};
    riscv_isa_pkg::AUIPC_OPCODE: word = {2'd1, 3'd2, 5'd0, 5'd0, 1'b1, 2'd0, 4'b0000};
    riscv_isa_pkg::LUI_OPCODE:   word = {2'd2, 3'd2, 5'd0, 5'd0, 1'b1, 2'd0, 4'b0000};
    riscv_isa_pkg::MISC_MEM_OPCODE: ok = (f3 == 3'd0);
    riscv_isa_pkg::OP_OPCODE: begin
      word = {2'd0, 3'd0, alu_code_for(f3, alt), 5'd0, 1'b1, 2'd0, 4'b0};
      ok   = (f7 == riscv_isa_pkg::FUNCT7_BASE) || (alt && f3 inside {3'd0, 3'd5});
    end
    riscv_isa_pkg::OP_IMM_OPCODE: begin
      word = {2'd0, 3'd1, alu_code_for(f3, alt && f3 == 3'd5), 5'd0, 1'b1, 2'd0, 4'b0};
      if (f3 == 3'd1 || f3 == 3'd5) begin
        ok = (f7 == riscv_isa_pkg::FUNCT7_BASE) || (alt && f3 == 3'd5);
      end
    end
    default: ok = 1'b0;
  endcase
  // bad quadrant or funct field leaves only the illegal bit
  if (instr[1:0] != 2'b11 || !ok) begin
    word = 24'h000008;
  end
  return word;
endfunction

`endif

//--- test/tb_instr_decoder.sv
module tb_instr_decoder;
  import riscv_isa_pkg::*;
  import decode_ctrl_pkg::*;

  `include "decoder_ref_model.svh"

  localparam int NUM_DIRECTED   = 100;
  localparam int NUM_RANDOM     = 1900;
  // four cycles per instruction covers the slowest random mix with a margin on top
  localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 4 + 100;

  logic       clk;
  logic       rst_n;
  logic       instr_valid_i;
  instr_t     instr_i;
  logic       instr_ready_o;
  logic       ctrl_valid_o;
  logic       ctrl_ready_i;
  a_sel_t     a_sel_o;
  b_sel_t     b_sel_o;
  alu_op_t    alu_op_o;
  logic       mem_req_o;
  logic       mem_we_o;
  mem_size_t  mem_size_o;
  logic       gpr_we_o;
  wb_sel_t    wb_sel_o;
  logic       illegal_instr_o;
  logic       branch_o;
  logic       jal_o;
  logic       jalr_o;

  // scoreboard of taken instructions and the cycle each one was taken
  instr_t      exp_q[$];
  int          take_q[$];
  int          cycle_count = 0;
  int          instrs_in = 0;
  int          words_out = 0;
  logic        latency_mode = 1'b0;
  logic        stalled = 1'b0;
  logic [23:0] held_word = '0;
  string       test_name = "reset state";

  instr_decoder_top instr_decoder_top_inst (
    .clk_i(clk), .rst_n_i(rst_n),
    .instr_valid_i(instr_valid_i), .instr_i(instr_i), .instr_ready_o(instr_ready_o),
    .ctrl_valid_o(ctrl_valid_o), .ctrl_ready_i(ctrl_ready_i),
    .a_sel_o(a_sel_o), .b_sel_o(b_sel_o), .alu_op_o(alu_op_o),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_size_o(mem_size_o),
    .gpr_we_o(gpr_we_o), .wb_sel_o(wb_sel_o), .illegal_instr_o(illegal_instr_o),
    .branch_o(branch_o), .jal_o(jal_o), .jalr_o(jalr_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAILED %s %s expected %0h actual %0h",
                          test_name, name, expected, actual));
    end
  endtask

  // same packing as the model word with the two top bits held at zero
  function automatic logic [23:0] pack_outputs();
    pack_outputs = {2'b00, a_sel_o, b_sel_o, alu_op_o, mem_req_o, mem_we_o, mem_size_o,
                    gpr_we_o, wb_sel_o, illegal_instr_o, branch_o, jal_o, jalr_o};
  endfunction

  // compares the outputs field by field against the model word
  task automatic compare_word(input instr_t instr);
    logic [23:0] exp;
    logic [23:0] act;
    exp = expected_ctrl_word(instr);
    act = pack_outputs();
    check_value("a_sel", exp[21:20], act[21:20]);
    check_value("b_sel", exp[19:17], act[19:17]);
    check_value("alu_op", exp[16:12], act[16:12]);
    check_value("mem_req", exp[11], act[11]);
    check_value("mem_we", exp[10], act[10]);
    check_value("mem_size", exp[9:7], act[9:7]);
    check_value("gpr_we", exp[6], act[6]);
    check_value("wb_sel", exp[5:4], act[5:4]);
    check_value("illegal", exp[3], act[3]);
    check_value("branch", exp[2], act[2]);
    check_value("jal", exp[1], act[1]);
    check_value("jalr", exp[0], act[0]);
  endtask

  function automatic opcode_t legal_opcode(input int unsigned idx);
    case (idx)
      0:       legal_opcode = LOAD_OPCODE;
      1:       legal_opcode = MISC_MEM_OPCODE;
      2:       legal_opcode = OP_IMM_OPCODE;
      3:       legal_opcode = AUIPC_OPCODE;
      4:       legal_opcode = STORE_OPCODE;
      5:       legal_opcode = OP_OPCODE;
      6:       legal_opcode = LUI_OPCODE;
      7:       legal_opcode = BRANCH_OPCODE;
      8:       legal_opcode = JALR_OPCODE;
      default: legal_opcode = JAL_OPCODE;
    endcase
  endfunction

  // about one word in five stays fully random and mostly lands on bad quadrants
  function automatic instr_t make_instr();
    instr_t      word;
    int unsigned f7_pick;
    word = $urandom;
    if ($urandom_range(99, 0) >= 20) begin
      word[6:2] = legal_opcode($urandom_range(9, 0));
      word[1:0] = 2'b11;
      f7_pick   = $urandom_range(3, 0);
      // the two named funct7 values are favoured so SUB, SRA and SRAI show up often
      if (f7_pick == 0) begin
        word[31:25] = FUNCT7_BASE;
      end else if (f7_pick == 1) begin
        word[31:25] = FUNCT7_ALT;
      end
    end
    return word;
  endfunction

  // a valid instruction is held until the DUT takes it
  task automatic drive_stream(input int count, input int valid_pct, input int ready_pct);
    int issued;
    int taken;
    issued = 0;
    taken  = 0;
    while (taken < count) begin
      @(posedge clk);
      if (instr_valid_i && instr_ready_o) taken++;
      if (!instr_valid_i || instr_ready_o) begin
        if (issued < count && $urandom_range(99, 0) < valid_pct) begin
          instr_i       <= make_instr();
          instr_valid_i <= 1'b1;
          issued++;
        end else begin
          instr_valid_i <= 1'b0;
        end
      end
      ctrl_ready_i <= ($urandom_range(99, 0) < ready_pct);
    end
  endtask

  task automatic drain_pipeline();
    ctrl_ready_i <= 1'b1;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // the monitor samples both streams on the edge before any NBA update lands
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES));
      end
      if (stalled) begin
        check_value("held valid", 1, ctrl_valid_o);
        check_value("held word", held_word, pack_outputs());
      end
      stalled   = ctrl_valid_o && !ctrl_ready_i;
      held_word = pack_outputs();
      if (ctrl_valid_o && ctrl_ready_i) begin
        if (exp_q.size() == 0) begin
          abort_run("a control word came out with no instruction in flight");
        end
        compare_word(exp_q.pop_front());
        // two edges from take to consume when the output side never stalls
        if (latency_mode) check_value("latency", 2, cycle_count - take_q[0]);
        void'(take_q.pop_front());
        words_out++;
      end
      if (instr_valid_i && instr_ready_o) begin
        exp_q.push_back(instr_i);
        take_q.push_back(cycle_count);
        instrs_in++;
      end
    end
  end

  initial begin
    rst_n         <= 1'b0;
    instr_valid_i <= 1'b0;
    instr_i       <= '0;
    ctrl_ready_i  <= 1'b0;
    void'($urandom(46));
    repeat (3) @(posedge clk);
    rst_n        <= 1'b1;
    ctrl_ready_i <= 1'b1;
    @(negedge clk);
    check_value("ctrl_valid", 0, ctrl_valid_o);
    check_value("instr_ready", 1, instr_ready_o);
    // back-to-back instructions with the consumer always ready
    test_name    = "directed latency";
    latency_mode = 1'b1;
    drive_stream(NUM_DIRECTED, 100, 100);
    drain_pipeline();
    latency_mode = 1'b0;
    test_name    = "random mix";
    drive_stream(NUM_RANDOM, 60, 70);
    drain_pipeline();
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0 || words_out != instrs_in ||
        instrs_in != NUM_DIRECTED + NUM_RANDOM) begin
      abort_run($sformatf("word count %0d does not match instruction count %0d",
                          words_out, instrs_in));
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- vlog.f
+incdir+include
design/riscv_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/decode_fields_if.sv
design/field_split_stage.sv
design/ctrl_decode_stage.sv
design/instr_decoder_top.sv
test/tb_instr_decoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_instr_decoder
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

SOURCES := $(wildcard design/*.sv) $(wildcard include/*.svh) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
